// File: rsa_pkg.sv
package rsa_pkg;

    // operand width, fixed by the arithmetic
    localparam int KEY_W = 256;

    // a value below N, or N, e, y themselves
    typedef logic [KEY_W-1:0] word_t;

    // montgomery sums reach up to 2N plus carry
    typedef logic [KEY_W+1:0] ext_t;

    // counts the 256 bit positions
    typedef logic [8:0] bit_cnt_t;

    // index of the last bit position in every loop
    localparam bit_cnt_t LAST_BIT = bit_cnt_t'(KEY_W - 1);

    // starting value of the result accumulator, plain 1
    localparam word_t WORD_ONE = word_t'(1);

    // one full request
    typedef struct packed {
        word_t n;
        word_t e;
        word_t y;
    } rsa_req_t;

    typedef enum logic [1:0] {
        MM_IDLE,
        MM_PREP,
        MM_CALC
    } mont_state_e;

    typedef enum logic {
        PM_IDLE,
        PM_SHIFT
    } premod_state_e;

    typedef enum logic [1:0] {
        EX_IDLE,
        EX_PREMOD,
        EX_MULT,
        EX_DONE_STEP
    } exp_state_e;

endpackage

// File: rsa_mont_mul.sv
`timescale 1ns/1ps

module rsa_mont_mul import rsa_pkg::*; (
    input  logic  i_clk,
    input  logic  i_rst,
    input  logic  i_start,
    input  word_t i_n,
    input  word_t i_a,
    input  word_t i_b,
    output word_t o_m,
    output logic  o_ready
);

    mont_state_e state_r, state_w;
    ext_t        m_r, m_w;
    bit_cnt_t    idx_r, idx_w;
    logic        ready_r, ready_w;

    ext_t n_ext;
    ext_t b_ext;
    ext_t sum_ab;
    ext_t sum_odd;

    assign n_ext   = {2'b00, i_n};
    assign b_ext   = {2'b00, i_b};
    assign o_m     = m_r[KEY_W-1:0];
    assign o_ready = ready_r;

    // one radix-2 step: add b on a set bit of a, make even with N
    always_comb begin
        sum_ab  = i_a[idx_r[7:0]] ? (m_r + b_ext) : m_r;
        sum_odd = sum_ab[0] ? (sum_ab + n_ext) : sum_ab;
    end

    always_comb begin
        state_w = state_r;
        m_w     = m_r;
        idx_w   = idx_r;
        ready_w = ready_r;
        case (state_r)
            MM_IDLE: begin
                if (i_start) begin
                    state_w = MM_PREP;
                    m_w     = '0;
                    idx_w   = '0;
                    ready_w = 1'b0;
                end
            end
            MM_PREP: begin
                state_w = MM_CALC;
                m_w     = sum_odd >> 1;
            end
            MM_CALC: begin
                if (idx_r == LAST_BIT) begin
                    state_w = MM_IDLE;
                    ready_w = 1'b1;
                    // bring the sum below N
                    if (m_r >= n_ext) begin
                        m_w = m_r - n_ext;
                    end
                end else begin
                    state_w = MM_PREP;
                    idx_w   = idx_r + 9'd1;
                end
            end
            default: begin
                state_w = MM_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state_r <= MM_IDLE;
            m_r     <= '0;
            idx_r   <= '0;
            ready_r <= 1'b0;
        end else begin
            state_r <= state_w;
            m_r     <= m_w;
            idx_r   <= idx_w;
            ready_r <= ready_w;
        end
    end

endmodule

// File: rsa_premod.sv
`timescale 1ns/1ps

module rsa_premod import rsa_pkg::*; (
    input  logic  i_clk,
    input  logic  i_rst,
    input  logic  i_start,
    input  word_t i_n,
    input  word_t i_y,
    output word_t o_t,
    output logic  o_ready
);

    premod_state_e state_r, state_w;
    word_t         t_r, t_w;
    bit_cnt_t      cnt_r, cnt_w;
    logic          ready_r, ready_w;

    ext_t n_ext;
    ext_t dbl;
    ext_t dbl_sub;

    assign n_ext   = {2'b00, i_n};
    assign o_t     = t_r;
    assign o_ready = ready_r;

    // double, then take N off once if needed
    assign dbl     = {1'b0, t_r, 1'b0};
    assign dbl_sub = dbl - n_ext;

    always_comb begin
        state_w = state_r;
        t_w     = t_r;
        cnt_w   = cnt_r;
        ready_w = ready_r;
        case (state_r)
            PM_IDLE: begin
                if (i_start) begin
                    state_w = PM_SHIFT;
                    t_w     = i_y;
                    cnt_w   = '0;
                    ready_w = 1'b0;
                end
            end
            PM_SHIFT: begin
                t_w   = (dbl >= n_ext) ? dbl_sub[KEY_W-1:0] : dbl[KEY_W-1:0];
                cnt_w = cnt_r + 9'd1;
                // 256th doubling lands together with ready
                if (cnt_r == LAST_BIT) begin
                    state_w = PM_IDLE;
                    ready_w = 1'b1;
                end
            end
            default: begin
                state_w = PM_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state_r <= PM_IDLE;
            t_r     <= '0;
            cnt_r   <= '0;
            ready_r <= 1'b0;
        end else begin
            state_r <= state_w;
            t_r     <= t_w;
            cnt_r   <= cnt_w;
            ready_r <= ready_w;
        end
    end

endmodule

// File: rsa_modexp.sv
`timescale 1ns/1ps

module rsa_modexp import rsa_pkg::*; (
    input  logic     i_clk,
    input  logic     i_rst,
    input  logic     i_start,
    input  rsa_req_t i_req,
    output word_t    o_result,
    output logic     o_ready
);

    exp_state_e state_r, state_w;
    word_t      result_r, result_w;
    word_t      power_r, power_w;
    bit_cnt_t   idx_r, idx_w;
    logic       ready_r, ready_w;
    logic       pm_start_r, pm_start_w;
    logic       mul_start_r, mul_start_w;

    word_t pm_t;
    logic  pm_ready;
    word_t mr_m;
    logic  mr_ready;
    word_t sq_m;
    logic  sq_ready;

    assign o_result = result_r;
    assign o_ready  = ready_r;

    // converts y into montgomery form
    rsa_premod premod_inst (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_start (pm_start_r),
        .i_n     (i_req.n),
        .i_y     (i_req.y),
        .o_t     (pm_t),
        .o_ready (pm_ready)
    );

    // result times power
    rsa_mont_mul mul_result (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_start (mul_start_r),
        .i_n     (i_req.n),
        .i_a     (result_r),
        .i_b     (power_r),
        .o_m     (mr_m),
        .o_ready (mr_ready)
    );

    // power squared
    rsa_mont_mul mul_square (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_start (mul_start_r),
        .i_n     (i_req.n),
        .i_a     (power_r),
        .i_b     (power_r),
        .o_m     (sq_m),
        .o_ready (sq_ready)
    );

    always_comb begin
        state_w     = state_r;
        result_w    = result_r;
        power_w     = power_r;
        idx_w       = idx_r;
        ready_w     = ready_r;
        pm_start_w  = 1'b0;
        mul_start_w = 1'b0;
        case (state_r)
            EX_IDLE: begin
                // request register is loaded on this edge, premod starts one later
                if (i_start) begin
                    state_w    = EX_PREMOD;
                    ready_w    = 1'b0;
                    pm_start_w = 1'b1;
                end
            end
            EX_PREMOD: begin
                // stale ready from the last run is still up while the strobe is
                if (!pm_start_r && pm_ready) begin
                    state_w     = EX_MULT;
                    power_w     = pm_t;
                    result_w    = WORD_ONE;
                    idx_w       = '0;
                    mul_start_w = 1'b1;
                end
            end
            EX_MULT: begin
                if (!mul_start_r && mr_ready && sq_ready) begin
                    state_w = EX_DONE_STEP;
                    if (i_req.e[idx_r[7:0]]) begin
                        result_w = mr_m;
                    end
                    power_w = sq_m;
                end
            end
            EX_DONE_STEP: begin
                if (idx_r == LAST_BIT) begin
                    state_w = EX_IDLE;
                    ready_w = 1'b1;
                end else begin
                    state_w     = EX_MULT;
                    idx_w       = idx_r + 9'd1;
                    mul_start_w = 1'b1;
                end
            end
            default: begin
                state_w = EX_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state_r     <= EX_IDLE;
            result_r    <= '0;
            power_r     <= '0;
            idx_r       <= '0;
            ready_r     <= 1'b0;
            pm_start_r  <= 1'b0;
            mul_start_r <= 1'b0;
        end else begin
            state_r     <= state_w;
            result_r    <= result_w;
            power_r     <= power_w;
            idx_r       <= idx_w;
            ready_r     <= ready_w;
            pm_start_r  <= pm_start_w;
            mul_start_r <= mul_start_w;
        end
    end

endmodule

// File: rsa_core.sv
`timescale 1ns/1ps

module rsa_core import rsa_pkg::*; (
    input  logic  i_clk,
    input  logic  i_rst,
    input  logic  i_start,
    input  word_t i_n,
    input  word_t i_e,
    input  word_t i_y,
    output word_t o_result,
    output logic  o_ready
);

    rsa_req_t req_r;
    logic     started_r;
    logic     req_load;

    // accept a new request only when no run is in flight
    assign req_load = i_start && (o_ready || !started_r);

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            started_r <= 1'b0;
        end else if (req_load) begin
            started_r <= 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (req_load) begin
            req_r.n <= i_n;
            req_r.e <= i_e;
            req_r.y <= i_y;
        end
    end

    rsa_modexp modexp_inst (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_start  (req_load),
        .i_req    (req_r),
        .o_result (o_result),
        .o_ready  (o_ready)
    );

endmodule

// File: tb_rsa_core.sv
`timescale 1ns/1ps

module tb_rsa_core import rsa_pkg::*; ();

    localparam int RESET_CYCLES   = 10;
    localparam int RUN_CYCLES     = 135000;
    localparam int RUN_COUNT      = 7;
    localparam int TIMEOUT_CYCLES = RUN_COUNT * RUN_CYCLES + 2 * RESET_CYCLES;

    logic  i_clk;
    logic  i_rst;
    logic  i_start;
    word_t i_n;
    word_t i_e;
    word_t i_y;
    word_t o_result;
    logic  o_ready;

    logic [31:0] lfsr_state;
    int          cycle_count;

    rsa_core rsa_core_inst (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_start  (i_start),
        .i_n      (i_n),
        .i_e      (i_e),
        .i_y      (i_y),
        .o_result (o_result),
        .o_ready  (o_ready)
    );

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic random_word(output word_t w);
        w = '0;
        for (int i = 0; i < KEY_W; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            w[i] = lfsr_state[0];
        end
    endtask

    // full-width odd N and a y brought below N with one subtraction
    task automatic random_request(output word_t n, output word_t e, output word_t y);
        random_word(n);
        n[KEY_W-1] = 1'b1;
        n[0]       = 1'b1;
        random_word(e);
        random_word(y);
        if (y >= n) begin
            y = y - n;
        end
    endtask

    // shift-and-add a times b mod n for a below n
    function automatic word_t mod_mul(input word_t a, input word_t b, input word_t n);
        logic [511:0] acc;
        logic [511:0] n_wide;
        acc    = '0;
        n_wide = {256'd0, n};
        for (int i = KEY_W - 1; i >= 0; i--) begin
            acc = acc << 1;
            if (acc >= n_wide) begin
                acc = acc - n_wide;
            end
            if (b[i]) begin
                acc = acc + {256'd0, a};
            end
            if (acc >= n_wide) begin
                acc = acc - n_wide;
            end
        end
        return acc[KEY_W-1:0];
    endfunction

    // right-to-left square and multiply
    function automatic word_t ref_modexp(input word_t n, input word_t e, input word_t y);
        word_t r;
        word_t p;
        r = WORD_ONE;
        p = y;
        for (int i = 0; i < KEY_W; i++) begin
            if (e[i]) begin
                r = mod_mul(r, p, n);
            end
            p = mod_mul(p, p, n);
        end
        return r;
    endfunction

    task automatic check_value(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h expected %h", name, got, exp);
            $display("Test FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic pulse_start(input word_t n, input word_t e, input word_t y);
        @(posedge i_clk);
        i_n     <= n;
        i_e     <= e;
        i_y     <= y;
        i_start <= 1'b1;
        @(posedge i_clk);
        i_start <= 1'b0;
    endtask

    task automatic wait_ready();
        while (!o_ready) begin
            @(negedge i_clk);
        end
    endtask

    // ready must drop right after the start edge
    task automatic run_request(input word_t n, input word_t e, input word_t y);
        pulse_start(n, e, y);
        @(negedge i_clk);
        check_value("o_ready", word_t'(o_ready), '0);
        wait_ready();
    endtask

    task automatic outputs_zero_after_reset();
        @(negedge i_clk);
        check_value("o_ready", word_t'(o_ready), '0);
        check_value("o_result", o_result, '0);
    endtask

    task automatic exp_one_gives_base();
        word_t n;
        word_t e;
        word_t y;
        random_request(n, e, y);
        run_request(n, WORD_ONE, y);
        check_value("o_result", o_result, y);
    endtask

    task automatic exp_zero_gives_one();
        run_request(word_t'(3233), '0, word_t'(65));
        check_value("o_result", o_result, WORD_ONE);
    endtask

    task automatic known_results_match();
        word_t n;
        word_t e;
        word_t y;
        run_request(word_t'(3233), word_t'(17), word_t'(65));
        check_value("o_result", o_result, word_t'(2790));
        check_value("o_result", o_result, ref_modexp(word_t'(3233), word_t'(17), word_t'(65)));
        random_request(n, e, y);
        run_request(n, e, y);
        check_value("o_result", o_result, ref_modexp(n, e, y));
    endtask

    // second strobe lands while the first run is busy
    task automatic busy_start_ignored();
        word_t n_a;
        word_t e_a;
        word_t y_a;
        word_t n_b;
        word_t e_b;
        word_t y_b;
        random_request(n_a, e_a, y_a);
        random_request(n_b, e_b, y_b);
        pulse_start(n_a, e_a, y_a);
        repeat (1000) @(posedge i_clk);
        pulse_start(n_b, e_b, y_b);
        @(negedge i_clk);
        check_value("o_ready", word_t'(o_ready), '0);
        wait_ready();
        check_value("o_result", o_result, ref_modexp(n_a, e_a, y_a));
        run_request(n_b, e_b, y_b);
        check_value("o_result", o_result, ref_modexp(n_b, e_b, y_b));
    endtask

    task automatic reset_mid_run_recovers();
        word_t n;
        word_t e;
        word_t y;
        random_request(n, e, y);
        pulse_start(n, e, y);
        repeat (500) @(posedge i_clk);
        i_rst <= 1'b1;
        repeat (RESET_CYCLES) @(posedge i_clk);
        i_rst <= 1'b0;
        @(negedge i_clk);
        check_value("o_ready", word_t'(o_ready), '0);
        check_value("o_result", o_result, '0);
        random_request(n, e, y);
        run_request(n, e, y);
        check_value("o_result", o_result, ref_modexp(n, e, y));
    endtask

    initial begin
        i_rst      = 1'b1;
        i_start    = 1'b0;
        i_n        = '0;
        i_e        = '0;
        i_y        = '0;
        lfsr_state = 32'hf985;
        repeat (RESET_CYCLES) @(posedge i_clk);
        i_rst <= 1'b0;
        outputs_zero_after_reset();
        exp_one_gives_base();
        exp_zero_gives_one();
        known_results_match();
        busy_start_ignored();
        reset_mid_run_recovers();
        $display("Test OK");
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge i_clk);
            cycle_count = cycle_count + 1;
        end
        $display("timeout: o_ready never rose");
        $display("Test FAILED");
        $fatal(1, "simulation timeout");
    end

endmodule

// File: rsa_core.f
rsa_pkg.sv
rsa_mont_mul.sv
rsa_premod.sv
rsa_modexp.sv
rsa_core.sv
tb_rsa_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_rsa_core
FILELIST  ?= rsa_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "Test OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
